// ==== hdl/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data memory size in 32-bit words
`define LSU_MEM_DEPTH 4096

// byte address width, only the low log2(depth)+2 bits reach the memory
`define LSU_ADDR_WIDTH 32

// lane logic is written for four bytes per word
`define LSU_DATA_WIDTH 32

// cycles from the memory read strobe to valid read data
`define LSU_READ_DELAY 2

`endif

// ==== hdl/lsu_op_pkg.sv ====
package lsu_op_pkg;

    // decoded memory operation
    typedef enum logic [3:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_NOP
    } mem_op_t;

    // funct3 field of RV32 loads and stores
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } funct3_t;

endpackage

// ==== hdl/lsu_state_pkg.sv ====
package lsu_state_pkg;

    // load/store controller states
    typedef enum logic [2:0] {
        ST_IDLE,        // waiting for a request
        ST_LOAD_WAIT,   // memory read in flight
        ST_LOAD_DONE,   // read data valid, capture into data_out
        ST_MERGE_WAIT,  // read phase of a byte or half-word store
        ST_STORE        // write strobe to memory
    } lsu_state_t;

endpackage

// ==== hdl/lsu_decode.sv ====
`timescale 1ns/1ps

module lsu_decode (
    input  logic                 read_en,
    input  logic                 write_en,
    input  logic [2:0]           funct3,
    output lsu_op_pkg::mem_op_t  op
);

    // decode table, fence and atomic codes would slot in here later
    always_comb begin
        op = lsu_op_pkg::OP_NOP;
        if (read_en) begin  // read wins when both strobes are up
            case (funct3)
                lsu_op_pkg::F3_B:  op = lsu_op_pkg::OP_LB;
                lsu_op_pkg::F3_H:  op = lsu_op_pkg::OP_LH;
                lsu_op_pkg::F3_W:  op = lsu_op_pkg::OP_LW;
                lsu_op_pkg::F3_BU: op = lsu_op_pkg::OP_LBU;
                lsu_op_pkg::F3_HU: op = lsu_op_pkg::OP_LHU;
                default:           op = lsu_op_pkg::OP_NOP;  // 3, 6, 7 not defined for loads
            endcase
        end else if (write_en) begin
            case (funct3)
                lsu_op_pkg::F3_B: op = lsu_op_pkg::OP_SB;
                lsu_op_pkg::F3_H: op = lsu_op_pkg::OP_SH;
                lsu_op_pkg::F3_W: op = lsu_op_pkg::OP_SW;
                default:          op = lsu_op_pkg::OP_NOP;  // no unsigned stores
            endcase
        end
    end

endmodule

// ==== hdl/lsu_execute.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_execute (
    input  logic                          clk,
    input  logic                          rstN,
    input  lsu_op_pkg::mem_op_t           op,
    input  logic [`LSU_ADDR_WIDTH-1:0]    address,
    input  logic [`LSU_DATA_WIDTH-1:0]    data_in,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic [`LSU_ADDR_WIDTH-3:0]    word_addr,
    output logic [1:0]                    byte_sel,
    output lsu_op_pkg::mem_op_t           op_reg,
    output logic [`LSU_DATA_WIDTH-1:0]    store_data,
    output logic                          load_capture,
    output logic                          ready
);

    localparam int CNT_W = $clog2(`LSU_READ_DELAY) + 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`LSU_READ_DELAY - 1);

    lsu_state_pkg::lsu_state_t state;
    lsu_state_pkg::lsu_state_t state_next;
    logic [CNT_W-1:0]          delay_cnt;  // cycles spent in a wait state
    logic                      accept;
    logic                      in_wait;
    logic                      is_load;

    assign accept  = (state == lsu_state_pkg::ST_IDLE) && (op != lsu_op_pkg::OP_NOP);
    assign in_wait = (state == lsu_state_pkg::ST_LOAD_WAIT) ||
                     (state == lsu_state_pkg::ST_MERGE_WAIT);
    assign is_load = (op == lsu_op_pkg::OP_LB) || (op == lsu_op_pkg::OP_LH) ||
                     (op == lsu_op_pkg::OP_LW) || (op == lsu_op_pkg::OP_LBU) ||
                     (op == lsu_op_pkg::OP_LHU);

    always_comb begin
        state_next = state;
        case (state)
            lsu_state_pkg::ST_IDLE: begin
                if (accept) begin
                    if (is_load)
                        state_next = lsu_state_pkg::ST_LOAD_WAIT;
                    else if (op == lsu_op_pkg::OP_SW)
                        state_next = lsu_state_pkg::ST_STORE;  // full word, no read needed
                    else
                        state_next = lsu_state_pkg::ST_MERGE_WAIT;
                end
            end
            lsu_state_pkg::ST_LOAD_WAIT: begin
                if (delay_cnt == LAST_CNT)
                    state_next = lsu_state_pkg::ST_LOAD_DONE;
            end
            lsu_state_pkg::ST_LOAD_DONE: state_next = lsu_state_pkg::ST_IDLE;
            lsu_state_pkg::ST_MERGE_WAIT: begin
                if (delay_cnt == LAST_CNT)
                    state_next = lsu_state_pkg::ST_STORE;  // old word now on mem_rdata
            end
            lsu_state_pkg::ST_STORE: state_next = lsu_state_pkg::ST_IDLE;
            default: state_next = lsu_state_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= lsu_state_pkg::ST_IDLE;
            delay_cnt <= '0;
            op_reg    <= lsu_op_pkg::OP_NOP;
        end else begin
            state <= state_next;
            if (in_wait && (delay_cnt != LAST_CNT))
                delay_cnt <= delay_cnt + 1'b1;
            else
                delay_cnt <= '0;
            if (accept)
                op_reg <= op;
        end
    end

    // request payload, held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            word_addr  <= address[`LSU_ADDR_WIDTH-1:2];
            byte_sel   <= address[1:0];
            store_data <= data_in;
        end
    end

    assign mem_read     = in_wait && (delay_cnt == '0);  // one pulse at start of the wait
    assign mem_write    = (state == lsu_state_pkg::ST_STORE);
    assign load_capture = (state == lsu_state_pkg::ST_LOAD_DONE);
    assign ready        = (state == lsu_state_pkg::ST_IDLE);

    a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rstN)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    a_busy_after_accept: assert property (@(posedge clk) disable iff (!rstN)
        (ready && (op != lsu_op_pkg::OP_NOP)) |=> !ready)
        else $error("ready still high after an accepted request");

    a_state_known: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(state))
        else $error("controller state unknown");

endmodule

// ==== hdl/lsu_result.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_result (
    input  logic                          clk,
    input  logic                          rstN,
    input  lsu_op_pkg::mem_op_t           op_reg,
    input  logic [1:0]                    byte_sel,
    input  logic [`LSU_DATA_WIDTH-1:0]    store_data,
    input  logic [`LSU_DATA_WIDTH-1:0]    mem_rdata,
    input  logic                          load_capture,
    output logic [`LSU_DATA_WIDTH-1:0]    mem_wdata,
    output logic [`LSU_DATA_WIDTH-1:0]    data_out
);

    logic [7:0]                  byte_lane;
    logic [15:0]                 half_lane;
    logic [`LSU_DATA_WIDTH-1:0]  load_val;

    assign byte_lane = mem_rdata[{byte_sel, 3'b000} +: 8];
    assign half_lane = mem_rdata[{byte_sel[1], 4'b0000} +: 16];  // bit 1 picks the half

    always_comb begin
        case (op_reg)
            lsu_op_pkg::OP_LB:  load_val = {{24{byte_lane[7]}}, byte_lane};
            lsu_op_pkg::OP_LBU: load_val = {24'h000000, byte_lane};
            lsu_op_pkg::OP_LH:  load_val = {{16{half_lane[15]}}, half_lane};
            lsu_op_pkg::OP_LHU: load_val = {16'h0000, half_lane};
            default:            load_val = mem_rdata;  // LW
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            data_out <= '0;
        else if (load_capture)
            data_out <= load_val;  // held until the next load
    end

    // store merge, only the addressed lane of the old word is replaced
    always_comb begin
        mem_wdata = mem_rdata;
        case (op_reg)
            lsu_op_pkg::OP_SB: mem_wdata[{byte_sel, 3'b000} +: 8] = store_data[7:0];
            lsu_op_pkg::OP_SH: mem_wdata[{byte_sel[1], 4'b0000} +: 16] = store_data[15:0];
            default:           mem_wdata = store_data;
        endcase
    end

    a_half_aligned: assert property (@(posedge clk) disable iff (!rstN)
        (op_reg inside {lsu_op_pkg::OP_LH, lsu_op_pkg::OP_LHU, lsu_op_pkg::OP_SH})
        |-> !byte_sel[0])
        else $error("half-word access at odd byte offset %0d", byte_sel);

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_memory (
    input  logic                          clk,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [`LSU_ADDR_WIDTH-3:0]    word_addr,
    input  logic [`LSU_DATA_WIDTH-1:0]    mem_wdata,
    output logic [`LSU_DATA_WIDTH-1:0]    mem_rdata
);

    localparam int IDX_W = $clog2(`LSU_MEM_DEPTH);

    logic [`LSU_DATA_WIDTH-1:0] mem [`LSU_MEM_DEPTH];
    logic [`LSU_DATA_WIDTH-1:0] rd_pipe [`LSU_READ_DELAY];  // read latency stages
    logic [IDX_W-1:0]           idx;

    assign idx = word_addr[IDX_W-1:0];  // upper address bits ignored

    always_ff @(posedge clk) begin
        if (mem_write)
            mem[idx] <= mem_wdata;
    end

    // stage 0 loads on a read and holds, later stages follow it
    always_ff @(posedge clk) begin
        if (mem_read)
            rd_pipe[0] <= mem[idx];
        for (int i = 1; i < `LSU_READ_DELAY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign mem_rdata = rd_pipe[`LSU_READ_DELAY-1];  // stays valid until the next read

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          read_en,
    input  logic                          write_en,
    input  logic [2:0]                    funct3,
    input  logic [`LSU_ADDR_WIDTH-1:0]    address,
    input  logic [`LSU_DATA_WIDTH-1:0]    data_in,
    output logic [`LSU_DATA_WIDTH-1:0]    data_out,
    output logic                          ready
);

    lsu_op_pkg::mem_op_t           op;
    lsu_op_pkg::mem_op_t           op_reg;
    logic                          mem_read;
    logic                          mem_write;
    logic [`LSU_ADDR_WIDTH-3:0]    word_addr;
    logic [1:0]                    byte_sel;
    logic [`LSU_DATA_WIDTH-1:0]    store_data;
    logic                          load_capture;
    logic [`LSU_DATA_WIDTH-1:0]    mem_rdata;
    logic [`LSU_DATA_WIDTH-1:0]    mem_wdata;  // merged store word

    lsu_decode u_decode (
        .read_en  (read_en),
        .write_en (write_en),
        .funct3   (funct3),
        .op       (op)
    );

    lsu_execute u_execute (
        .clk          (clk),
        .rstN         (rstN),
        .op           (op),
        .address      (address),
        .data_in      (data_in),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .word_addr    (word_addr),
        .byte_sel     (byte_sel),
        .op_reg       (op_reg),
        .store_data   (store_data),
        .load_capture (load_capture),
        .ready        (ready)
    );

    lsu_result u_result (
        .clk          (clk),
        .rstN         (rstN),
        .op_reg       (op_reg),
        .byte_sel     (byte_sel),
        .store_data   (store_data),
        .mem_rdata    (mem_rdata),
        .load_capture (load_capture),
        .mem_wdata    (mem_wdata),
        .data_out     (data_out)
    );

    data_memory u_memory (
        .clk       (clk),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .word_addr (word_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu;

    localparam int AW = `LSU_ADDR_WIDTH;
    localparam int DW = `LSU_DATA_WIDTH;
    localparam int WAIT_LIMIT = 50;  // cycles allowed for ready to return
    localparam int SHADOW_WORDS = 64;

    // RV32 funct3 codes for loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    logic          clk;
    logic          rstN;
    logic          read_en;
    logic          write_en;
    logic [2:0]    funct3;
    logic [AW-1:0] address;
    logic [DW-1:0] data_in;
    logic [DW-1:0] data_out;
    logic          ready;

    logic [31:0] shadow [SHADOW_WORDS];  // expected memory contents
    logic [31:0] last_load;  // expected data_out after the latest load
    logic [31:0] rng_state;
    int          test_num;
    int          tests_failed;
    int          test_errs;
    int          total_errs;
    int          checks;
    string       test_name;

    lsu_top u_lsu_top (
        .clk      (clk),
        .rstN     (rstN),
        .read_en  (read_en),
        .write_en (write_en),
        .funct3   (funct3),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .ready    (ready)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic logic [AW-1:0] make_addr(input logic [5:0] idx, input logic [1:0] off);
        return AW'({idx, off});
    endfunction

    // lane select and extension as RV32 defines it
    function automatic logic [31:0] expected_load(input logic [2:0] f3, input logic [31:0] word,
                                                  input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (32'(off) * 8));
        h = 16'(word >> (32'(off[1]) * 16));
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h000000, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0000, h};
            default: return word;
        endcase
    endfunction

    task automatic apply_store(input logic [2:0] f3, input logic [5:0] idx,
                               input logic [1:0] off, input logic [31:0] data);
        case (f3)
            F3_B:    shadow[idx][32'(off) * 8 +: 8] = data[7:0];
            F3_H:    shadow[idx][32'(off[1]) * 16 +: 16] = data[15:0];
            default: shadow[idx] = data;
        endcase
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, test_name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
    endtask

    task automatic check_data(input logic [31:0] exp, input string what);
        checks++;
        a_data_out: assert (data_out === exp) else begin
            $display("Mismatch data_out: expected %08h, got %08h (%s)", exp, data_out, what);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        a_condition: assert (cond) else begin
            $display("Error: %s", msg);
            test_errs++;
        end
    endtask

    // one-cycle strobe that the DUT samples at the second edge
    task automatic send_request(input logic rd, input logic wr, input logic [2:0] f3,
                                input logic [AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        read_en  <= rd;
        write_en <= wr;
        funct3   <= f3;
        address  <= addr;
        data_in  <= data;
        @(posedge clk);
        read_en  <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((ready !== 1'b1) && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (ready !== 1'b1) begin
            $display("Timeout: ready did not come back within %0d cycles in test %0d",
                     WAIT_LIMIT, test_num);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic store(input logic [2:0] f3, input logic [5:0] idx,
                         input logic [1:0] off, input logic [31:0] data);
        send_request(1'b0, 1'b1, f3, make_addr(idx, off), data);
        wait_ready();
        apply_store(f3, idx, off, data);
    endtask

    task automatic load_and_check(input logic [2:0] f3, input logic [5:0] idx,
                                  input logic [1:0] off);
        logic [31:0] junk;
        logic [31:0] exp;
        draw(junk);  // store data is don't-care on a load
        send_request(1'b1, 1'b0, f3, make_addr(idx, off), junk);
        wait_ready();
        exp = expected_load(f3, shadow[idx], off);
        last_load = exp;
        check_data(exp, $sformatf("funct3 %0d at %08h", f3, make_addr(idx, off)));
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [5:0]  idx;
        logic [5:0]  idx_b;
        logic [2:0]  bad_load [3];
        clk = 1'b0;
        rstN = 1'b0;
        read_en = 1'b0;
        write_en = 1'b0;
        funct3 = 3'b000;
        address = '0;
        data_in = '0;
        rng_state = 32'h0cfee7b7;
        last_load = 32'h0;
        test_num = 0;
        tests_failed = 0;
        total_errs = 0;
        checks = 0;
        bad_load = '{3'd3, 3'd6, 3'd7};

        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        start_test("reset state");
        @(negedge clk);
        check_true(ready === 1'b1, "ready is not high after reset");
        check_data(32'h0, "after reset");
        report_test();

        start_test("word round trip");
        for (int i = 0; i < SHADOW_WORDS; i++) begin  // fill every word since memory has no reset
            draw(d);
            store(F3_W, 6'(i), 2'd0, d);
        end
        for (int i = 0; i < 24; i++) begin
            draw(r);
            draw(d);
            store(F3_W, r[5:0], 2'd0, d);
        end
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            load_and_check(F3_W, 6'(i), 2'd0);
        end
        report_test();

        start_test("partial stores");
        for (int n = 0; n < 6; n++) begin
            draw(r);
            idx = r[5:0];
            for (int o = 0; o < 4; o++) begin
                draw(d);
                store(F3_B, idx, 2'(o), d);
                load_and_check(F3_W, idx, 2'd0);
            end
            for (int o = 0; o < 4; o += 2) begin
                draw(d);
                store(F3_H, idx, 2'(o), d);
                load_and_check(F3_W, idx, 2'd0);
            end
        end
        report_test();

        start_test("load extension");
        for (int n = 0; n < 8; n++) begin
            draw(r);
            draw(d);
            if (n % 4 == 0)
                d = d | 32'h80808080;  // every sign bit set
            else if (n % 4 == 1)
                d = d & 32'h7f7f7f7f;  // every sign bit clear
            store(F3_W, r[5:0], 2'd0, d);
            for (int o = 0; o < 4; o++) begin
                load_and_check(F3_B, r[5:0], 2'(o));
                load_and_check(F3_BU, r[5:0], 2'(o));
            end
            for (int o = 0; o < 4; o += 2) begin
                load_and_check(F3_H, r[5:0], 2'(o));
                load_and_check(F3_HU, r[5:0], 2'(o));
            end
        end
        report_test();

        start_test("ignored requests");
        draw(r);
        idx = r[5:0];
        idx_b = idx ^ 6'd1;
        for (int i = 0; i < 3; i++) begin
            send_request(1'b1, 1'b0, bad_load[i], make_addr(idx, 2'd0), 32'h0);
            @(negedge clk);
            check_true(ready === 1'b1, $sformatf("ready fell after load funct3 %0d", bad_load[i]));
            check_data(last_load, "data_out after an invalid load");
        end
        for (int f = 3; f < 8; f++) begin
            send_request(1'b0, 1'b1, 3'(f), make_addr(idx, 2'd0), ~shadow[idx]);
            @(negedge clk);
            check_true(ready === 1'b1, $sformatf("ready fell after store funct3 %0d", f));
        end
        load_and_check(F3_W, idx, 2'd0);
        send_request(1'b1, 1'b0, F3_W, make_addr(idx, 2'd0), 32'h0);
        @(posedge clk);
        write_en <= 1'b1;  // store attempt while the load is in flight
        funct3   <= F3_W;
        address  <= make_addr(idx_b, 2'd0);
        data_in  <= ~shadow[idx_b];
        @(negedge clk);
        check_true(ready === 1'b0, "ready high while a load was in flight");
        @(posedge clk);
        write_en <= 1'b0;
        wait_ready();
        check_data(shadow[idx], "load around a dropped store");
        load_and_check(F3_W, idx_b, 2'd0);
        report_test();

        start_test("read priority");
        draw(r);
        idx = r[5:0];
        send_request(1'b1, 1'b1, F3_W, make_addr(idx, 2'd0), ~shadow[idx]);
        wait_ready();
        check_data(shadow[idx], "both strobes with funct3 2");
        load_and_check(F3_W, idx, 2'd0);
        send_request(1'b1, 1'b1, F3_B, make_addr(idx, 2'd1), ~shadow[idx]);
        wait_ready();
        check_data(expected_load(F3_B, shadow[idx], 2'd1), "both strobes with funct3 0");
        load_and_check(F3_W, idx, 2'd0);
        report_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, checks, total_errs);
        if (total_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/lsu_op_pkg.sv
hdl/lsu_state_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_execute.sv
hdl/lsu_result.sv
hdl/data_memory.sv
hdl/lsu_top.sv
testbench/tb_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lsu -f all.f -o sim_lsu

./obj_dir/sim_lsu | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
